// File: hw/hist_cfg_pkg.sv
// widths and data types of the histogram datapath, imported by the RTL and the testbench
`default_nettype none

package hist_cfg_pkg;

    localparam int PIXEL_W    = 8;                    // sensor pixel
    localparam int NUM_COLORS = 4;                    // bayer colors
    localparam int COLOR_W    = 2;                    // color index
    localparam int NUM_BINS   = 256;                  // bins per color
    localparam int BIN_W      = 8;                    // bin address
    localparam int COUNT_W    = 32;                   // bin count and output word
    localparam int COORD_W    = 16;                   // window coordinates, line/pixel counters
    localparam int HIST_WORDS = NUM_COLORS * NUM_BINS; // 1024 words per readout

    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [BIN_W-1:0]   bin_t;
    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [COLOR_W-1:0] color_t;

endpackage

`default_nettype wire

// File: hw/hist_ctrl_pkg.sv
// state and color encodings for the window tracker, the readout sequencer and the testbench
`default_nettype none

package hist_ctrl_pkg;

    // row parity in the upper bit, column parity in the lower, both from frame start
    typedef enum logic [1:0] {
        BAYER_R0C0 = 2'd0,
        BAYER_R0C1 = 2'd1,
        BAYER_R1C0 = 2'd2,
        BAYER_R1C1 = 2'd3
    } bayer_color_e;

    typedef enum logic [1:0] {
        FRM_IDLE       = 2'd0, // no frame being accumulated
        FRM_TOP_MARGIN = 2'd1, // lines above the window
        FRM_IN_WINDOW  = 2'd2,
        FRM_DONE       = 2'd3  // single cycle, frame_done
    } frame_state_e;

    typedef enum logic [1:0] {
        RD_IDLE       = 2'd0,
        RD_REQUEST    = 2'd1, // settle delay, then hist_rq_o until grant
        RD_STREAM     = 2'd2, // one bin read per cycle
        RD_CLEAR_TAIL = 2'd3  // last words still in the output pipeline
    } readout_state_e;

endpackage

`default_nettype wire

// File: hw/hist_bank_if.sv
// update and read lines of one color bank, fed by the window tracker and drained by the readout
`default_nettype none

interface hist_bank_if
    import hist_cfg_pkg::*;
();

    logic   upd_valid; // one-cycle increment strobe
    bin_t   upd_bin;   // bin to increment
    logic   rd_en;     // read-and-clear strobe
    bin_t   rd_addr;
    count_t rd_data;   // valid the cycle after rd_en

    modport feed (
        output upd_valid,
        output upd_bin
    );

    modport bank (
        input  upd_valid,
        input  upd_bin,
        input  rd_en,
        input  rd_addr,
        output rd_data
    );

    modport drain (
        output rd_en,
        output rd_addr,
        input  rd_data
    );

endinterface

`default_nettype wire

// File: hw/hist_window.sv
// tracks lines, pixels and bayer phase of each frame and sends in-window pixels to the color banks
`default_nettype none

module hist_window
    import hist_cfg_pkg::*, hist_ctrl_pkg::*;
(
    input  logic        pclk,
    input  logic        hist_rst_pclk,
    input  logic        sof_i,            // frame start, at least one cycle ahead of hact_i
    input  logic        hact_i,
    input  pixel_t      pix_i,
    input  logic        hist_en_i,
    input  coord_t      win_left_i,
    input  coord_t      win_top_i,
    input  coord_t      win_width_m1_i,
    input  coord_t      win_height_m1_i,
    input  logic        busy_i,           // readout still pending
    output logic        frame_done_o,
    hist_bank_if.feed   banks [NUM_COLORS]
);

    frame_state_e frame_state;
    coord_t       left_r;
    coord_t       width_m1_r;
    coord_t       height_m1_r;
    coord_t       vcnt;        // lines left in the current section
    coord_t       hcnt;        // pixels left in the current section
    logic         hact_d;
    logic         hact_fall;
    logic         h_left;      // still in the left margin
    logic         h_win;       // inside the window, after its first pixel
    logic         row_odd;
    logic         col_odd;
    logic         pix_in;
    bayer_color_e pix_color;

    assign hact_fall    = hact_d && !hact_i;
    assign pix_color    = bayer_color_e'({row_odd, col_odd});
    assign frame_done_o = (frame_state == FRM_DONE);

    // first window pixel is the one seen with hcnt at zero in the left margin
    assign pix_in = hact_i && (frame_state == FRM_IN_WINDOW) &&
                    (h_win || (h_left && (hcnt == '0)));

    always_ff @(posedge pclk) begin
        if (sof_i) begin
            left_r      <= win_left_i;
            width_m1_r  <= win_width_m1_i;
            height_m1_r <= win_height_m1_i;
        end
    end

    // vertical position, frames only start when enabled and no readout is pending
    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            frame_state <= FRM_IDLE;
            vcnt        <= '0;
        end else if (frame_state == FRM_DONE) begin
            frame_state <= FRM_IDLE;
        end else if (sof_i) begin
            if (!hist_en_i || busy_i) begin
                frame_state <= FRM_IDLE;              // skip this frame
            end else if (win_top_i == '0) begin
                frame_state <= FRM_IN_WINDOW;
                vcnt        <= win_height_m1_i;
            end else begin
                frame_state <= FRM_TOP_MARGIN;
                vcnt        <= win_top_i - 1'b1;
            end
        end else if (hact_fall) begin
            case (frame_state)
                FRM_TOP_MARGIN: begin
                    if (vcnt == '0) begin
                        frame_state <= FRM_IN_WINDOW;
                        vcnt        <= height_m1_r;
                    end else begin
                        vcnt <= vcnt - 1'b1;
                    end
                end
                FRM_IN_WINDOW: begin
                    if (vcnt == '0) begin
                        frame_state <= FRM_DONE;      // last window line ended
                    end else begin
                        vcnt <= vcnt - 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // horizontal position, reloaded during line blanking
    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            h_left <= 1'b0;
            h_win  <= 1'b0;
            hcnt   <= '0;
        end else if (!hact_i) begin
            h_left <= 1'b1;
            h_win  <= 1'b0;
            hcnt   <= sof_i ? win_left_i : left_r; // new left before the first line
        end else if (h_left) begin
            if (hcnt == '0) begin
                h_left <= 1'b0;
                h_win  <= (width_m1_r != '0);
                hcnt   <= width_m1_r - 1'b1;
            end else begin
                hcnt <= hcnt - 1'b1;
            end
        end else if (h_win) begin
            if (hcnt == '0) begin
                h_win <= 1'b0;
            end else begin
                hcnt <= hcnt - 1'b1;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            hact_d  <= 1'b0;
            row_odd <= 1'b0;
            col_odd <= 1'b0;
        end else begin
            hact_d <= hact_i;
            if (sof_i) begin
                row_odd <= 1'b0;
                col_odd <= 1'b0;
            end else begin
                if (hact_fall) begin
                    row_odd <= !row_odd;
                end
                col_odd <= hact_i && !col_odd; // toggles per pixel, cleared in blanking
            end
        end
    end

    // adjacent pixels differ in color, so a bank sees at most every other cycle
    for (genvar c = 0; c < NUM_COLORS; c++) begin : g_feed
        always_ff @(posedge pclk) begin
            if (hist_rst_pclk) begin
                banks[c].upd_valid <= 1'b0;
            end else begin
                banks[c].upd_valid <= pix_in && (pix_color == bayer_color_e'(c));
            end
        end

        always_ff @(posedge pclk) begin
            if (pix_in) begin
                banks[c].upd_bin <= bin_t'(pix_i); // pixel value is the bin
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/hist_bank.sv
// count memory of one bayer color, incremented per pixel and cleared as it is read out
`default_nettype none

module hist_bank
    import hist_cfg_pkg::*;
(
    input  logic      pclk,
    hist_bank_if.bank port
);

    count_t mem [NUM_BINS];
    count_t rd_q;      // shared read register
    bin_t   rd_sel;
    logic   rd_act;
    logic   wr_pend;   // increment write due this cycle
    bin_t   wr_bin;
    logic   wr_en;
    bin_t   wr_addr;
    count_t wr_data;

    initial begin
        for (int i = 0; i < NUM_BINS; i++) begin
            mem[i] = '0;
        end
    end

    assign rd_act = port.upd_valid || port.rd_en;
    assign rd_sel = port.rd_en ? port.rd_addr : port.upd_bin;

    // increment write and clear write never meet, readout waits for the frame
    assign wr_en   = wr_pend || port.rd_en;
    assign wr_addr = wr_pend ? wr_bin : port.rd_addr;
    assign wr_data = wr_pend ? rd_q + 1'b1 : '0;

    assign port.rd_data = rd_q;

    always_ff @(posedge pclk) begin
        wr_pend <= port.upd_valid;
        if (port.upd_valid) begin
            wr_bin <= port.upd_bin;
        end
    end

    always_ff @(posedge pclk) begin
        if (rd_act) begin
            rd_q <= mem[rd_sel];
        end
    end

    // read-first, so a clear returns the old count
    always @(posedge pclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/hist_readout.sv
// requests the output bus after each frame and streams all bins, color by color, clearing them
`default_nettype none

module hist_readout
    import hist_cfg_pkg::*, hist_ctrl_pkg::*;
(
    input  logic        pclk,
    input  logic        hist_rst_pclk,
    input  logic        frame_done_i,
    input  logic        hist_grant_i,
    output logic        busy_o,
    output logic        hist_rq_o,
    output count_t      hist_do_o,
    output logic        hist_dv_o,
    hist_bank_if.drain  banks [NUM_COLORS]
);

    readout_state_e                rd_state;
    logic [$clog2(HIST_WORDS)-1:0] word_cnt;   // color in upper bits, bin in lower
    logic                          settle;     // lets the last increments land
    logic                          rd_go;
    logic                          rd_vld;
    color_t                        cur_color;
    color_t                        rd_color;
    count_t                        bank_data [NUM_COLORS];

    assign cur_color = word_cnt[BIN_W +: COLOR_W];
    assign busy_o    = (rd_state != RD_IDLE);

    // first read in the grant cycle itself
    assign rd_go = (rd_state == RD_STREAM) ||
                   ((rd_state == RD_REQUEST) && hist_rq_o && hist_grant_i);

    for (genvar c = 0; c < NUM_COLORS; c++) begin : g_drain
        assign banks[c].rd_en   = rd_go && (cur_color == color_t'(c));
        assign banks[c].rd_addr = word_cnt[BIN_W-1:0];
        assign bank_data[c]     = banks[c].rd_data;
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            rd_state  <= RD_IDLE;
            hist_rq_o <= 1'b0;
            settle    <= 1'b0;
            word_cnt  <= '0;
            rd_vld    <= 1'b0;
            hist_dv_o <= 1'b0;
        end else begin
            rd_vld    <= rd_go;
            hist_dv_o <= rd_vld;
            if (rd_go) begin
                word_cnt <= word_cnt + 1'b1; // wraps to zero after the last word
            end
            case (rd_state)
                RD_IDLE: begin
                    if (frame_done_i) begin
                        rd_state <= RD_REQUEST;
                        settle   <= 1'b1;
                    end
                end
                RD_REQUEST: begin
                    settle <= 1'b0;
                    if (settle) begin
                        hist_rq_o <= 1'b1;
                    end else if (hist_rq_o && hist_grant_i) begin
                        hist_rq_o <= 1'b0;
                        rd_state  <= RD_STREAM;
                    end
                end
                RD_STREAM: begin
                    if (&word_cnt) begin
                        rd_state <= RD_CLEAR_TAIL;
                    end
                end
                RD_CLEAR_TAIL: begin
                    if (!rd_vld) begin
                        rd_state <= RD_IDLE; // last word is on hist_do_o now
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        rd_color <= cur_color;
        if (rd_vld) begin
            hist_do_o <= bank_data[rd_color];
        end
    end

endmodule

`default_nettype wire

// File: hw/sens_histogram.sv
// per-color histogram top, joins the window tracker, four color banks and the readout sequencer
`default_nettype none

module sens_histogram
    import hist_cfg_pkg::*;
(
    input  logic   pclk,
    input  logic   hist_rst_pclk,
    input  logic   sof_i,
    input  logic   hact_i,
    input  pixel_t pix_i,
    input  logic   hist_en_i,        // sampled at sof_i
    input  coord_t win_left_i,
    input  coord_t win_top_i,
    input  coord_t win_width_m1_i,
    input  coord_t win_height_m1_i,
    input  logic   hist_grant_i,
    output logic   hist_rq_o,
    output count_t hist_do_o,
    output logic   hist_dv_o
);

    logic frame_done;
    logic busy;       // readout pending, blocks new frames

    hist_bank_if bank_if [NUM_COLORS] ();

    hist_window hist_window_inst (
        .pclk            (pclk),
        .hist_rst_pclk   (hist_rst_pclk),
        .sof_i           (sof_i),
        .hact_i          (hact_i),
        .pix_i           (pix_i),
        .hist_en_i       (hist_en_i),
        .win_left_i      (win_left_i),
        .win_top_i       (win_top_i),
        .win_width_m1_i  (win_width_m1_i),
        .win_height_m1_i (win_height_m1_i),
        .busy_i          (busy),
        .frame_done_o    (frame_done),
        .banks           (bank_if)
    );

    for (genvar c = 0; c < NUM_COLORS; c++) begin : g_bank
        hist_bank hist_bank_inst (
            .pclk (pclk),
            .port (bank_if[c])
        );
    end

    hist_readout hist_readout_inst (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .frame_done_i  (frame_done),
        .hist_grant_i  (hist_grant_i),
        .busy_o        (busy),
        .hist_rq_o     (hist_rq_o),
        .hist_do_o     (hist_do_o),
        .hist_dv_o     (hist_dv_o),
        .banks         (bank_if)
    );

endmodule

`default_nettype wire

// File: test/sens_histogram_asserts.sv
// concurrent checks on bank strobes and readout burst length, bound into the banks and the readout
`default_nettype none

module sens_histogram_asserts
    import hist_cfg_pkg::*;
(
    input logic pclk,
    input logic rst_i,
    input logic upd_valid_i,
    input logic rd_en_i,
    input logic dv_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int dv_run; // cycles of the current valid burst so far

    always_ff @(posedge pclk) begin
        if (rst_i || !dv_i) begin
            dv_run <= 0;
        end else begin
            dv_run <= dv_run + 1;
        end
    end

    upd_spacing: assert property (@(posedge pclk) disable iff (rst_i)
        upd_valid_i |=> !upd_valid_i)
        else $error("update strobe on two consecutive cycles");

    rd_upd_apart: assert property (@(posedge pclk) disable iff (rst_i)
        upd_valid_i |-> !rd_en_i)
        else $error("read strobe in the same cycle as an update strobe");

    dv_not_long: assert property (@(posedge pclk) disable iff (rst_i)
        dv_i |-> (dv_run < HIST_WORDS))
        else $error("valid burst longer than one readout");

    dv_exact: assert property (@(posedge pclk) disable iff (rst_i)
        $fell(dv_i) |-> (dv_run == HIST_WORDS))
        else $error("valid burst ended at %0d words", dv_run);

endmodule

bind hist_bank sens_histogram_asserts bank_asserts_inst (
    .pclk        (pclk),
    .rst_i       (1'b0),
    .upd_valid_i (port.upd_valid),
    .rd_en_i     (port.rd_en),
    .dv_i        (1'b0)
);

bind hist_readout sens_histogram_asserts readout_asserts_inst (
    .pclk        (pclk),
    .rst_i       (hist_rst_pclk),
    .upd_valid_i (1'b0),
    .rd_en_i     (1'b0),
    .dv_i        (hist_dv_o)
);

`default_nettype wire

// File: test/tb_sens_histogram.sv
// testbench for the bayer histogram, drives frames and readouts and checks them against a count model
`default_nettype none

module tb_sens_histogram
    import hist_cfg_pkg::*, hist_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 4;
    localparam int LINES        = 8;
    localparam int LINE_LEN     = 16;
    localparam int BLANK        = 4;                // line and frame blanking
    localparam int FRAME_CYCLES = BLANK + LINES * (LINE_LEN + BLANK);
    localparam int NUM_FRAMES   = 8;
    localparam int NUM_READOUTS = 6;
    localparam int WATCHDOG_NS  =
        (NUM_FRAMES * FRAME_CYCLES + NUM_READOUTS * 1100) * 2 * CLK_PERIOD;

    logic   pclk;
    logic   hist_rst_pclk;
    logic   sof;
    logic   hact;
    pixel_t pix;
    logic   hist_en;
    coord_t win_left;
    coord_t win_top;
    coord_t win_width_m1;
    coord_t win_height_m1;
    logic   hist_grant;
    logic   hist_rq;
    count_t hist_do;
    logic   hist_dv;

    count_t     ref_cnt [NUM_COLORS][NUM_BINS]; // expected bin counts
    logic [7:0] lfsr_q;
    int         errors;
    int         checks;

    sens_histogram sens_histogram_inst (
        .pclk            (pclk),
        .hist_rst_pclk   (hist_rst_pclk),
        .sof_i           (sof),
        .hact_i          (hact),
        .pix_i           (pix),
        .hist_en_i       (hist_en),
        .win_left_i      (win_left),
        .win_top_i       (win_top),
        .win_width_m1_i  (win_width_m1),
        .win_height_m1_i (win_height_m1),
        .hist_grant_i    (hist_grant),
        .hist_rq_o       (hist_rq),
        .hist_do_o       (hist_do),
        .hist_dv_o       (hist_dv)
    );

    initial begin
        pclk = 1'b0;
        forever #(CLK_PERIOD / 2) pclk = ~pclk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic next_pixel(output pixel_t p);
        for (int i = 0; i < PIXEL_W; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            p[i]   = lfsr_q[0]; // one step per bit
        end
    endtask

    function automatic logic in_window(input int x, input int y);
        return (x >= int'(win_left)) && (x <= int'(win_left) + int'(win_width_m1)) &&
               (y >= int'(win_top)) && (y <= int'(win_top) + int'(win_height_m1));
    endfunction

    task automatic clear_model();
        for (int c = 0; c < NUM_COLORS; c++) begin
            for (int b = 0; b < NUM_BINS; b++) begin
                ref_cnt[c][b] = '0;
            end
        end
    endtask

    task automatic check_word(input count_t got, input count_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic set_window(input coord_t left, input coord_t top,
                              input coord_t width_m1, input coord_t height_m1);
        win_left      = left;
        win_top       = top;
        win_width_m1  = width_m1;
        win_height_m1 = height_m1;
    endtask

    // one frame, counted into the model only when the DUT should accept it
    task automatic drive_frame(input logic count_it, input logic use_const, input pixel_t cval);
        pixel_t       p;
        bayer_color_e col;
        sof = 1'b1;
        @(negedge pclk);
        sof = 1'b0;
        repeat (BLANK - 1) @(negedge pclk);
        for (int y = 0; y < LINES; y++) begin
            for (int x = 0; x < LINE_LEN; x++) begin
                if (use_const) begin
                    p = cval;
                end else begin
                    next_pixel(p);
                end
                hact = 1'b1;
                pix  = p;
                col  = bayer_color_e'({y[0], x[0]}); // parity from frame origin
                if (count_it && in_window(x, y)) begin
                    ref_cnt[col][p] = ref_cnt[col][p] + 1;
                end
                @(negedge pclk);
            end
            hact = 1'b0;
            pix  = '0;
            repeat (BLANK) @(negedge pclk);
        end
    endtask

    // waits for the request, grants it and compares all 1024 words
    task automatic read_and_check(input string what);
        int     waited;
        color_t col;
        bin_t   bin;
        waited = 0;
        while (!hist_rq && waited < 300) begin
            @(negedge pclk);
            waited++;
        end
        if (!hist_rq) begin
            errors++;
            $display("%s: no readout request within %0d cycles", what, waited);
        end else begin
            hist_grant = 1'b1;
            @(negedge pclk);
            hist_grant = 1'b0;
            check_level(hist_rq, 1'b0, {what, ": request after grant"});
            check_level(hist_dv, 1'b0, {what, ": valid one cycle after grant"});
            @(negedge pclk);
            for (int n = 0; n < HIST_WORDS; n++) begin
                col = color_t'(n / NUM_BINS);
                bin = bin_t'(n % NUM_BINS);
                check_level(hist_dv, 1'b1, $sformatf("%s: valid at word %0d", what, n));
                check_word(hist_do, ref_cnt[col][bin],
                           $sformatf("%s: color %0d bin %0d", what, col, bin));
                @(negedge pclk);
            end
            check_level(hist_dv, 1'b0, {what, ": valid after last word"});
        end
        clear_model(); // banks are cleared by the read
    endtask

    task automatic expect_no_request(input int cycles, input string what);
        repeat (cycles) begin
            check_level(hist_rq, 1'b0, what);
            @(negedge pclk);
        end
    endtask

    task automatic test_full_window();
        set_window(16'd0, 16'd0, coord_t'(LINE_LEN - 1), coord_t'(LINES - 1));
        drive_frame(1'b1, 1'b0, '0);
        read_and_check("full window");
    endtask

    task automatic test_offset_window();
        set_window(16'd3, 16'd2, 16'd4, 16'd2);
        drive_frame(1'b1, 1'b0, '0);
        read_and_check("offset window");
    endtask

    task automatic test_clear_on_read();
        set_window(16'd0, 16'd0, coord_t'(LINE_LEN - 1), coord_t'(LINES - 1));
        drive_frame(1'b1, 1'b0, '0);
        read_and_check("first of two frames");
        drive_frame(1'b1, 1'b0, '0);
        read_and_check("second of two frames");
    endtask

    task automatic test_disabled_frame();
        hist_en = 1'b0;
        drive_frame(1'b0, 1'b0, '0);
        hist_en = 1'b1;
        expect_no_request(100, "request after disabled frame");
    endtask

    task automatic test_pending_readout();
        set_window(16'd0, 16'd0, coord_t'(LINE_LEN - 1), coord_t'(LINES - 1));
        drive_frame(1'b1, 1'b0, '0);
        drive_frame(1'b0, 1'b0, '0); // starts while the request waits
        read_and_check("frame during pending readout");
        expect_no_request(100, "request after skipped frame");
    endtask

    task automatic test_constant_pixel();
        set_window(16'd0, 16'd0, coord_t'(LINE_LEN - 1), coord_t'(LINES - 1));
        drive_frame(1'b1, 1'b1, 8'h5a);
        read_and_check("constant pixel");
    endtask

    initial begin
        hist_rst_pclk = 1'b1;
        sof           = 1'b0;
        hact          = 1'b0;
        pix           = '0;
        hist_en       = 1'b1;
        hist_grant    = 1'b0;
        set_window(16'd0, 16'd0, coord_t'(LINE_LEN - 1), coord_t'(LINES - 1));
        lfsr_q = 8'd1;
        errors = 0;
        checks = 0;
        clear_model();
        repeat (2) @(posedge pclk);
        @(negedge pclk);
        hist_rst_pclk = 1'b0;
        check_level(hist_rq, 1'b0, "request after reset");
        check_level(hist_dv, 1'b0, "valid after reset");

        test_full_window();
        test_offset_window();
        test_clear_on_read();
        test_disabled_frame();
        test_pending_readout();
        test_constant_pixel();

        repeat (4) @(negedge pclk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hw/hist_cfg_pkg.sv
hw/hist_ctrl_pkg.sv
hw/hist_bank_if.sv
hw/hist_window.sv
hw/hist_bank.sv
hw/hist_readout.sv
hw/sens_histogram.sv
test/sens_histogram_asserts.sv
test/tb_sens_histogram.sv

// File: Makefile
# Verilator build and run of the histogram testbench

VERILATOR ?= verilator
TOP       ?= tb_sens_histogram
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= >>> PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF -- "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
